//--- logic/ifu_params.svh
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// width of byte addresses and of one instruction word
`define IFU_ADDR_W 32

// bytes per cache line, four words
`define IFU_LINE_BYTES 16

// number of direct-mapped cache lines
`define IFU_NUM_LINES 8

// first fetch address after reset
`define IFU_RESET_PC 32'h0000_0000

`endif

//--- logic/ifu_pkg.sv
`default_nettype none

`include "ifu_params.svh"

package ifu_pkg;

    // address split, offset bits then index bits then tag
    localparam int unsigned OFFSET_W = $clog2(`IFU_LINE_BYTES);
    localparam int unsigned INDEX_W  = $clog2(`IFU_NUM_LINES);
    localparam int unsigned TAG_W    = `IFU_ADDR_W - INDEX_W - OFFSET_W;

    // byte address and instruction word
    typedef logic [`IFU_ADDR_W-1:0] addr_t;
    typedef logic [`IFU_ADDR_W-1:0] word_t;

    // whole line, word 0 sits in the low bits
    typedef logic [`IFU_LINE_BYTES*8-1:0] line_t;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // refill handshake states
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_RELEASE
    } fill_state_e;

endpackage : ifu_pkg

`default_nettype wire

//--- logic/icache_lookup_if.sv
`timescale 1ns/100ps
`default_nettype none

// lookup path between fetch stage and instruction cache
// purely combinational, hit and instr follow addr in the same cycle
interface icache_lookup_if import ifu_pkg::*; ();

    // current pc
    addr_t addr;
    // fetch wants a word this cycle
    logic  lookup;
    // word at addr is present
    logic  hit;
    // selected word
    word_t instr;

    // requester side
    modport fetch (
        output addr,
        output lookup,
        input  hit,
        input  instr
    );

    // cache side
    modport cache (
        input  addr,
        input  lookup,
        output hit,
        output instr
    );

endinterface : icache_lookup_if

`default_nettype wire

//--- logic/icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module icache import ifu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // lookup from fetch
    icache_lookup_if.cache lk,

    // line refill towards memory
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  logic  mem_ack_i,
    input  line_t mem_line_i
);

    // storage arrays, one entry per line
    line_t data_q [`IFU_NUM_LINES];
    tag_t  tag_q  [`IFU_NUM_LINES];
    logic [`IFU_NUM_LINES-1:0] valid_q;

    // lookup address fields
    tag_t   lk_tag;
    index_t lk_index;
    logic [OFFSET_W-3:0] lk_word;
    line_t  rd_line;

    // refill control
    fill_state_e state_q;
    fill_state_e state_d;
    addr_t  fill_addr_q;
    index_t fill_index;
    tag_t   fill_tag;
    logic   fill_start;
    logic   fill_done;

    assign lk_tag   = lk.addr[`IFU_ADDR_W-1 -: TAG_W];
    assign lk_index = lk.addr[OFFSET_W +: INDEX_W];
    // word within the line, byte bits dropped
    assign lk_word  = lk.addr[OFFSET_W-1:2];

    assign rd_line = data_q[lk_index];

    // hit needs a valid entry with matching tag
    assign lk.hit   = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
    assign lk.instr = rd_line[lk_word * `IFU_ADDR_W +: `IFU_ADDR_W];

    // fields of the line being refilled
    assign fill_index = fill_addr_q[OFFSET_W +: INDEX_W];
    assign fill_tag   = fill_addr_q[`IFU_ADDR_W-1 -: TAG_W];

    // a missing lookup opens a refill
    // ack must be low first, previous handshake fully closed
    assign fill_start = (state_q == FILL_IDLE) && lk.lookup && !lk.hit && !mem_ack_i;

    // line arrives on the edge where ack is seen
    assign fill_done = (state_q == FILL_REQ) && mem_ack_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            FILL_IDLE: begin
                if (fill_start) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                // req drops once we leave this state
                if (mem_ack_i) begin
                    state_d = FILL_RELEASE;
                end
            end
            FILL_RELEASE: begin
                // wait for memory to drop ack
                if (!mem_ack_i) begin
                    state_d = FILL_IDLE;
                end
            end
            default: begin
                state_d = FILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= FILL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // line-aligned address, held for the whole handshake
    always_ff @(posedge clk_i) begin
        if (fill_start) begin
            fill_addr_q <= {lk.addr[`IFU_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

    // valid bits, cleared by reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_done) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // data and tag written together with valid
    always_ff @(posedge clk_i) begin
        if (fill_done) begin
            data_q[fill_index] <= mem_line_i;
            tag_q[fill_index]  <= fill_tag;
        end
    end

    // req follows the state, address comes from the latch
    assign mem_req_o  = (state_q == FILL_REQ);
    assign mem_addr_o = fill_addr_q;

endmodule : icache

`default_nettype wire

//--- logic/ifu_fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_fetch_stage import ifu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // back-pressure from decode
    input  logic  stall_i,

    // redirect from write-back
    input  logic  branch_taken_i,
    input  addr_t branch_target_i,

    // IF/ID register towards decode
    output logic  valid_o,
    output word_t instr_o,
    output addr_t pc_o,

    // line refill, straight through from the cache
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  logic  mem_ack_i,
    input  line_t mem_line_i
);

    icache_lookup_if lk_if ();

    // program counter
    addr_t pc_q;
    addr_t pc_d;

    // IF/ID register
    logic  valid_q;
    logic  valid_d;
    word_t instr_q;
    addr_t pc_out_q;
    // capture payload only on an accepted hit
    logic  load_out;

    icache u_icache (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .lk         (lk_if.cache),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_ack_i  (mem_ack_i),
        .mem_line_i (mem_line_i)
    );

    // look up the current pc whenever decode can take a word
    assign lk_if.addr   = pc_q;
    assign lk_if.lookup = rst_n_i && !stall_i;

    // next pc and output register control
    // redirect beats stall, stall beats hit
    always_comb begin
        pc_d     = pc_q;
        valid_d  = valid_q;
        load_out = 1'b0;
        if (branch_taken_i) begin
            // kill whatever is in flight
            pc_d    = branch_target_i;
            valid_d = 1'b0;
        end else if (stall_i) begin
            // freeze pc and IF/ID
            pc_d    = pc_q;
            valid_d = valid_q;
        end else if (lk_if.hit) begin
            pc_d     = pc_q + addr_t'(4);
            valid_d  = 1'b1;
            load_out = 1'b1;
        end else begin
            // miss, hold pc and send a bubble
            valid_d = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q    <= `IFU_RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_d;
            valid_q <= valid_d;
        end
    end

    // instruction and its pc, no reset
    always_ff @(posedge clk_i) begin
        if (load_out) begin
            instr_q  <= lk_if.instr;
            pc_out_q <= pc_q;
        end
    end

    assign valid_o = valid_q;
    assign instr_o = instr_q;
    assign pc_o    = pc_out_q;

endmodule : ifu_fetch_stage

`default_nettype wire

//--- logic/ifu_top.sv
`timescale 1ns/100ps
`default_nettype none

// instruction-fetch subsystem boundary
// the cache lives inside the fetch stage
module ifu_top import ifu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // decode back-pressure
    input  logic  stall_i,

    // taken branch from write-back, one-cycle pulse
    input  logic  branch_taken_i,
    input  addr_t branch_target_i,

    // fetched instruction to decode
    output logic  valid_o,
    output word_t instr_o,
    output addr_t pc_o,

    // four-phase line refill to memory
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  logic  mem_ack_i,
    input  line_t mem_line_i
);

    ifu_fetch_stage u_fetch (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .valid_o         (valid_o),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        // refill side of the cache
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_ack_i       (mem_ack_i),
        .mem_line_i      (mem_line_i)
    );

endmodule : ifu_top

`default_nettype wire

//--- verification/ifu_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

// line-granular instruction memory for the refill port
// answers each req with a four-phase handshake and random delays
module ifu_mem_model import ifu_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  mem_req_i,
    input  addr_t mem_addr_i,
    output logic  mem_ack_o,
    output line_t mem_line_o
);

    integer seed = 98513;
    int unsigned delay;

    // word at byte address a is a xor a5a5_0000
    function automatic line_t build_line(input addr_t base);
        line_t l;
        addr_t a;
        l = '0;
        for (int i = 0; i < `IFU_LINE_BYTES / 4; i++) begin
            a = base + addr_t'(4 * i);
            l[i*32 +: 32] = a ^ 32'hA5A5_0000;
        end
        return l;
    endfunction

    // outputs change on the falling edge only
    initial begin
        mem_ack_o  = 1'b0;
        mem_line_o = '0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && mem_req_i && !mem_ack_o) begin
                // 0 to 5 cycles before the line shows up
                delay = {$random(seed)} % 6;
                repeat (delay) @(negedge clk_i);
                mem_line_o = build_line(mem_addr_i);
                mem_ack_o  = 1'b1;
                // hold ack until the cache lets go of req
                while (mem_req_i) begin
                    @(negedge clk_i);
                end
                // then 0 to 3 cycles before ack falls
                delay = {$random(seed)} % 4;
                repeat (delay) @(negedge clk_i);
                mem_ack_o = 1'b0;
            end
        end
    end

endmodule : ifu_mem_model

`default_nettype wire

//--- verification/ifu_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "ifu_params.svh"

module ifu_top_tb import ifu_pkg::*; ();

    // watchdog budget, fetched words times worst miss cost plus slack
    localparam int fetch_budget    = 300;
    localparam int miss_cost       = 12;
    localparam int margin_cycles   = 400;
    localparam int watchdog_cycles = fetch_budget * miss_cost + margin_cycles;

    logic  clk_i;
    logic  rst_n_i;
    logic  stall_i;
    logic  branch_taken_i;
    addr_t branch_target_i;
    logic  valid_o;
    word_t instr_o;
    addr_t pc_o;
    logic  mem_req_o;
    addr_t mem_addr_o;
    logic  mem_ack_i;
    line_t mem_line_i;

    integer seed = 98513;
    int error_count = 0;

    // pc the next valid output must carry
    addr_t exp_pc;
    // lines written into the cache since reset, one record per index
    addr_t filled_line [`IFU_NUM_LINES];
    logic [`IFU_NUM_LINES-1:0] filled_valid;
    index_t req_index;
    logic refetch;

    ifu_top dut_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .valid_o         (valid_o),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_ack_i       (mem_ack_i),
        .mem_line_i      (mem_line_i)
    );

    ifu_mem_model u_mem (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .mem_req_i  (mem_req_o),
        .mem_addr_i (mem_addr_o),
        .mem_ack_o  (mem_ack_i),
        .mem_line_o (mem_line_i)
    );

    function automatic word_t expected_word(input addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // redirect beats stall, an output is used up when not stalled
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_pc <= `IFU_RESET_PC;
        end else if (branch_taken_i) begin
            exp_pc <= branch_target_i;
        end else if (valid_o && !stall_i) begin
            exp_pc <= exp_pc + 32'd4;
        end
    end

    // a line counts as filled on the edge where req meets ack
    assign req_index = mem_addr_o[OFFSET_W +: INDEX_W];
    assign refetch   = filled_valid[req_index] && (filled_line[req_index] == mem_addr_o);

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            filled_valid <= '0;
        end else if (mem_req_o && mem_ack_i) begin
            filled_valid[req_index] <= 1'b1;
            filled_line[req_index]  <= mem_addr_o;
        end
    end

    data_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> (instr_o == expected_word(pc_o)))
        else begin
            error_count++;
            $display("mismatch at %0t: instr %h at pc %h", $time, instr_o, pc_o);
        end

    order_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> (pc_o == exp_pc))
        else begin
            error_count++;
            $display("mismatch at %0t: pc %h, expected %h", $time, pc_o, exp_pc);
        end

    stall_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !branch_taken_i) |=> ($stable(valid_o)
            && (!valid_o || ($stable(pc_o) && $stable(instr_o)))))
        else begin
            error_count++;
            $display("mismatch at %0t: output changed under stall", $time);
        end

    redirect_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        branch_taken_i |=> !valid_o)
        else begin
            error_count++;
            $display("mismatch at %0t: valid output right after a redirect", $time);
        end

    align_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |-> (mem_addr_o[OFFSET_W-1:0] == '0))
        else begin
            error_count++;
            $display("at %0t the refill address %h is not line aligned", $time, mem_addr_o);
        end

    addr_hold_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o |=> (!mem_req_o || $stable(mem_addr_o)))
        else begin
            error_count++;
            $display("at %0t the refill address moved while req was high", $time);
        end

    req_hold_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_req_o && !mem_ack_i) |=> mem_req_o)
        else begin
            error_count++;
            $display("at %0t the cache dropped req before ack came", $time);
        end

    // ack may already answer a fresh req, so look at ack when req was raised
    req_rise_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(mem_req_o) |-> (!$past(mem_ack_i) && !refetch))
        else begin
            error_count++;
            $display("at %0t a refill of %h started with ack high or for a line already held",
                     $time, mem_addr_o);
        end

    // one-cycle redirect pulse, optionally with decode stalling too
    task automatic redirect(input addr_t target, input logic with_stall);
        @(negedge clk_i);
        branch_taken_i  = 1'b1;
        branch_target_i = target;
        stall_i         = with_stall;
        @(negedge clk_i);
        branch_taken_i  = 1'b0;
        stall_i         = 1'b0;
    endtask

    // run until the word at target leaves the stage, stalling at random
    task automatic wait_for_pc(input addr_t target, input int stall_pct);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk_i);
            seen    = valid_o && (pc_o == target);
            stall_i = ({$random(seed)} % 100) < stall_pct;
        end
        stall_i = 1'b0;
    endtask

    initial begin
        addr_t target;
        int idle;
        rst_n_i         = 1'b0;
        stall_i         = 1'b0;
        branch_taken_i  = 1'b0;
        branch_target_i = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // straight line over 12 lines, last word at 0xbc
        wait_for_pc(32'h0000_00BC, 0);
        // second pass over the first 8 lines
        redirect(32'h0000_0000, 1'b0);
        wait_for_pc(32'h0000_007C, 0);
        // same range with stall pulses
        redirect(32'h0000_0000, 1'b0);
        wait_for_pc(32'h0000_007C, 30);
        // random word targets inside the first 8 lines
        for (int n = 0; n < 12; n++) begin
            target = addr_t'(({$random(seed)} % 32) * 4);
            redirect(target, n[0]);
            wait_for_pc(target, 20);
            idle = {$random(seed)} % 6;
            repeat (idle) @(negedge clk_i);
        end
        repeat (8) @(negedge clk_i);

        $display("run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("watchdog ran out after %0d cycles, %0d errors so far",
                 watchdog_cycles, error_count);
        $display("Simulation failed");
        $finish;
    end

endmodule : ifu_top_tb

`default_nettype wire

//--- ifu.f
+incdir+logic
logic/ifu_pkg.sv
logic/icache_lookup_if.sv
logic/icache.sv
logic/ifu_fetch_stage.sv
logic/ifu_top.sv
verification/ifu_mem_model.sv
verification/ifu_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= ifu_top_tb
FILELIST  ?= ifu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
